/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ******************************
    // widths
    // ******************************
    localparam int DATA_W     = 16;
    localparam int INST_W     = 16;
    localparam int PC_W       = 16;
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 8;

    // ******************************
    // encodings
    // ******************************
    // major opcode, inst[15:11]
    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_B     = 5'b00010,
        OP_BEQZ  = 5'b00100,
        OP_ADDIU = 5'b01001,
        OP_LI    = 5'b01101,
        OP_LW    = 5'b10011,
        OP_SW    = 5'b11011,
        OP_RRR   = 5'b11100,
        OP_LOGIC = 5'b11101
    } opcode_e;

    // ALU_ADD has to stay zero for a cleared ctrl_t to be a bubble
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_ALWAYS,
        BR_ON_ZERO
    } branch_e;

    // ******************************
    // pipeline structs
    // ******************************
    typedef struct packed {
        alu_op_e                alu_op;
        branch_e                branch;
        logic                   b_is_imm;
        logic [DATA_W-1:0]      imm;
        logic                   reg_we;
        logic [REG_ADDR_W-1:0]  dest;
        logic                   mem_read;
        logic                   mem_write;
    } ctrl_t;

    typedef struct packed {
        logic                   reg_we;
        logic [REG_ADDR_W-1:0]  dest;
        logic                   mem_read;
        logic                   mem_write;
        logic [DATA_W-1:0]      alu_result;
        logic [DATA_W-1:0]      store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                   reg_we;
        logic [REG_ADDR_W-1:0]  dest;
        logic                   mem_read;
        logic [DATA_W-1:0]      alu_result;
        logic [DATA_W-1:0]      load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                           clk_50MHz,
    input  wire logic                           rst,
    input  wire logic                           stall_i,
    input  wire logic                           branch_taken_i,
    input  wire logic [cpu_pkg::PC_W-1:0]       branch_target_i,
    input  wire logic [cpu_pkg::INST_W-1:0]     inst_i,
    output logic [cpu_pkg::PC_W-1:0]            pc_o,
    output logic [cpu_pkg::INST_W-1:0]          if_id_inst_o,
    output logic [cpu_pkg::PC_W-1:0]            if_id_pc_next_o
);

    logic [cpu_pkg::PC_W-1:0] pc_q;
    logic [cpu_pkg::PC_W-1:0] pc_plus;

    assign pc_plus = pc_q + 1'b1;
    assign pc_o    = pc_q;

    // branch redirect wins over a load-use freeze
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc_q <= '0;
        end else if (branch_taken_i) begin
            pc_q <= branch_target_i;
        end else if (!stall_i) begin
            pc_q <= pc_plus;
        end
    end

    // IF/ID
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            if_id_inst_o    <= {cpu_pkg::OP_NOP, 11'b0};
            if_id_pc_next_o <= '0;
        end else if (branch_taken_i) begin
            if_id_inst_o    <= {cpu_pkg::OP_NOP, 11'b0};
        end else if (!stall_i) begin
            if_id_inst_o    <= inst_i;
            if_id_pc_next_o <= pc_plus;
        end
    end

    pc_known_a: assert property (@(posedge clk_50MHz) disable iff (!rst)
        !$isunknown(pc_q));

endmodule

`default_nettype wire

/* decode/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire logic [cpu_pkg::INST_W-1:0]     inst_i,
    output cpu_pkg::ctrl_t                      ctrl_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]      src_a_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]      src_b_o,
    output logic                                uses_b_o
);

    logic [cpu_pkg::REG_ADDR_W-1:0] rx;
    logic [cpu_pkg::REG_ADDR_W-1:0] ry;
    logic [cpu_pkg::REG_ADDR_W-1:0] rz;

    assign rx = inst_i[10:8];
    assign ry = inst_i[7:5];
    assign rz = inst_i[4:2];

    assign src_a_o = rx;
    assign src_b_o = ry;

    always_comb begin
        // anything unrecognised stays a bubble
        ctrl_o   = '0;
        uses_b_o = 1'b0;
        ctrl_o.dest = rx;
        case (cpu_pkg::opcode_e'(inst_i[15:11]))
            cpu_pkg::OP_ADDIU: begin
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.imm      = {{8{inst_i[7]}}, inst_i[7:0]};
                ctrl_o.reg_we   = 1'b1;
            end
            cpu_pkg::OP_LI: begin
                ctrl_o.alu_op   = cpu_pkg::ALU_PASS_B;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.imm      = {8'b0, inst_i[7:0]};
                ctrl_o.reg_we   = 1'b1;
            end
            cpu_pkg::OP_BEQZ: begin
                ctrl_o.branch = cpu_pkg::BR_ON_ZERO;
                ctrl_o.imm    = {{8{inst_i[7]}}, inst_i[7:0]};
            end
            cpu_pkg::OP_B: begin
                ctrl_o.branch = cpu_pkg::BR_ALWAYS;
                ctrl_o.imm    = {{5{inst_i[10]}}, inst_i[10:0]};
            end
            cpu_pkg::OP_LW: begin
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.imm      = {{11{inst_i[4]}}, inst_i[4:0]};
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.dest     = ry;
                ctrl_o.mem_read = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.imm       = {{11{inst_i[4]}}, inst_i[4:0]};
                ctrl_o.mem_write = 1'b1;
                uses_b_o         = 1'b1;
            end
            cpu_pkg::OP_RRR: begin
                // funct 01 addu, 11 subu
                ctrl_o.alu_op = inst_i[1] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                ctrl_o.reg_we = inst_i[0];
                ctrl_o.dest   = rz;
                uses_b_o      = 1'b1;
            end
            cpu_pkg::OP_LOGIC: begin
                ctrl_o.alu_op = inst_i[0] ? cpu_pkg::ALU_OR : cpu_pkg::ALU_AND;
                ctrl_o.reg_we = (inst_i[4:1] == 4'b0110);
                uses_b_o      = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                               clk_50MHz,
    input  wire logic                               rst,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     rd_addr_a_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     rd_addr_b_i,
    input  wire logic                               wr_en_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     wr_addr_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]         wr_data_i,
    output logic [cpu_pkg::DATA_W-1:0]              rd_data_a_o,
    output logic [cpu_pkg::DATA_W-1:0]              rd_data_b_o
);

    logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            regs <= '{default: '0};
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through lets WB and ID share a cycle
    assign rd_data_a_o = (wr_en_i && wr_addr_i == rd_addr_a_i) ? wr_data_i : regs[rd_addr_a_i];
    assign rd_data_b_o = (wr_en_i && wr_addr_i == rd_addr_b_i) ? wr_data_i : regs[rd_addr_b_i];

    wr_data_known_a: assert property (@(posedge clk_50MHz) disable iff (!rst)
        wr_en_i |-> !$isunknown(wr_data_i));

endmodule

`default_nettype wire

/* decode/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     src_a_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     src_b_i,
    input  wire logic                               uses_b_i,
    input  wire logic                               ex_mem_read_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     ex_dest_i,
    output logic                                    stall_o
);

    logic hit_a;
    logic hit_b;

    // rx counts as read by every opcode
    assign hit_a = (ex_dest_i == src_a_i);
    assign hit_b = uses_b_i && (ex_dest_i == src_b_i);

    assign stall_o = ex_mem_read_i && (hit_a || hit_b);

endmodule

`default_nettype wire

/* execute/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     src_a_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     src_b_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]         reg_a_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]         reg_b_i,
    input  wire cpu_pkg::ex_mem_t                   ex_mem_i,
    input  wire cpu_pkg::mem_wb_t                   mem_wb_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]         wb_data_i,
    output logic [cpu_pkg::DATA_W-1:0]              fwd_a_o,
    output logic [cpu_pkg::DATA_W-1:0]              fwd_b_o
);

    // youngest producer wins
    function automatic logic [cpu_pkg::DATA_W-1:0] pick(
        input logic [cpu_pkg::REG_ADDR_W-1:0] src,
        input logic [cpu_pkg::DATA_W-1:0]     reg_val
    );
        if (ex_mem_i.reg_we && ex_mem_i.dest == src) begin
            return ex_mem_i.alu_result;
        end else if (mem_wb_i.reg_we && mem_wb_i.dest == src) begin
            return wb_data_i;
        end
        return reg_val;
    endfunction

    assign fwd_a_o = pick(src_a_i, reg_a_i);
    assign fwd_b_o = pick(src_b_i, reg_b_i);

endmodule

`default_nettype wire

/* execute/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire logic                               clk_50MHz,
    input  wire logic                               rst,
    input  wire logic                               stall_i,
    input  wire cpu_pkg::ctrl_t                     ctrl_i,
    input  wire logic [cpu_pkg::PC_W-1:0]           pc_next_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     src_a_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0]     src_b_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]         reg_a_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]         reg_b_i,
    input  wire cpu_pkg::mem_wb_t                   mem_wb_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]         wb_data_i,
    output logic                                    branch_taken_o,
    output logic [cpu_pkg::PC_W-1:0]                branch_target_o,
    output logic                                    ex_mem_read_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]          ex_dest_o,
    output cpu_pkg::ex_mem_t                        ex_mem_o
);

    cpu_pkg::ctrl_t                 id_ex_ctrl;
    logic [cpu_pkg::PC_W-1:0]       id_ex_pc_next;
    logic [cpu_pkg::REG_ADDR_W-1:0] id_ex_src_a;
    logic [cpu_pkg::REG_ADDR_W-1:0] id_ex_src_b;
    logic [cpu_pkg::DATA_W-1:0]     id_ex_reg_a;
    logic [cpu_pkg::DATA_W-1:0]     id_ex_reg_b;
    logic [cpu_pkg::DATA_W-1:0]     fwd_a;
    logic [cpu_pkg::DATA_W-1:0]     fwd_b;
    logic [cpu_pkg::DATA_W-1:0]     op_b;
    logic [cpu_pkg::DATA_W-1:0]     alu_result;

    // ******************************
    // ID/EXE
    // ******************************
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex_ctrl <= '0;
        end else if (stall_i || branch_taken_o) begin
            id_ex_ctrl <= '0;
        end else begin
            id_ex_ctrl <= ctrl_i;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        id_ex_pc_next <= pc_next_i;
        id_ex_src_a   <= src_a_i;
        id_ex_src_b   <= src_b_i;
        id_ex_reg_a   <= reg_a_i;
        id_ex_reg_b   <= reg_b_i;
    end

    assign ex_mem_read_o = id_ex_ctrl.mem_read;
    assign ex_dest_o     = id_ex_ctrl.dest;

    // ******************************
    // operands and ALU
    // ******************************
    forward_unit u_forward (
        .src_a_i   (id_ex_src_a),
        .src_b_i   (id_ex_src_b),
        .reg_a_i   (id_ex_reg_a),
        .reg_b_i   (id_ex_reg_b),
        .ex_mem_i  (ex_mem_o),
        .mem_wb_i  (mem_wb_i),
        .wb_data_i (wb_data_i),
        .fwd_a_o   (fwd_a),
        .fwd_b_o   (fwd_b)
    );

    assign op_b = id_ex_ctrl.b_is_imm ? id_ex_ctrl.imm : fwd_b;

    always_comb begin
        case (id_ex_ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_result = fwd_a + op_b;
            cpu_pkg::ALU_SUB: alu_result = fwd_a - op_b;
            cpu_pkg::ALU_AND: alu_result = fwd_a & op_b;
            cpu_pkg::ALU_OR:  alu_result = fwd_a | op_b;
            default:          alu_result = op_b;
        endcase
    end

    // relative to the instruction after the branch
    assign branch_target_o = id_ex_pc_next + id_ex_ctrl.imm;
    assign branch_taken_o  = (id_ex_ctrl.branch == cpu_pkg::BR_ALWAYS) ||
                             (id_ex_ctrl.branch == cpu_pkg::BR_ON_ZERO && fwd_a == '0);

    // EXE/MEM
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.reg_we     <= id_ex_ctrl.reg_we;
            ex_mem_o.dest       <= id_ex_ctrl.dest;
            ex_mem_o.mem_read   <= id_ex_ctrl.mem_read;
            ex_mem_o.mem_write  <= id_ex_ctrl.mem_write;
            ex_mem_o.alu_result <= alu_result;
            ex_mem_o.store_data <= fwd_b;
        end
    end

    // a resolving branch has a known decision and target
    branch_known_a: assert property (@(posedge clk_50MHz) disable iff (!rst)
        id_ex_ctrl.branch != cpu_pkg::BR_NONE |->
            !$isunknown({branch_taken_o, branch_target_o}));

endmodule

`default_nettype wire

/* rtl/writeback_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input  wire logic                           clk_50MHz,
    input  wire logic                           rst,
    input  wire cpu_pkg::ex_mem_t               ex_mem_i,
    input  wire logic [cpu_pkg::DATA_W-1:0]     mem_rdata_i,
    output cpu_pkg::mem_wb_t                    mem_wb_o,
    output logic [cpu_pkg::DATA_W-1:0]          wb_data_o
);

    // MEM/WB
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o.reg_we     <= ex_mem_i.reg_we;
            mem_wb_o.dest       <= ex_mem_i.dest;
            mem_wb_o.mem_read   <= ex_mem_i.mem_read;
            mem_wb_o.alu_result <= ex_mem_i.alu_result;
            mem_wb_o.load_data  <= mem_rdata_i;
        end
    end

    // loads take the memory word
    assign wb_data_o = mem_wb_o.mem_read ? mem_wb_o.load_data : mem_wb_o.alu_result;

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire logic                           clk_50MHz,
    input  wire logic                           rst,
    // instruction memory
    output logic [cpu_pkg::PC_W-1:0]            imem_addr_o,
    input  wire logic [cpu_pkg::INST_W-1:0]     inst_i,
    // data memory
    output logic [cpu_pkg::DATA_W-1:0]          dmem_addr_o,
    output logic [cpu_pkg::DATA_W-1:0]          dmem_wdata_o,
    output logic                                dmem_we_o,
    input  wire logic [cpu_pkg::DATA_W-1:0]     dmem_rdata_i,
    // register write-back
    output logic                                wb_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]      wb_addr_o,
    output logic [cpu_pkg::DATA_W-1:0]          wb_data_o
);

    logic                               stall;
    logic                               branch_taken;
    logic [cpu_pkg::PC_W-1:0]           branch_target;
    logic [cpu_pkg::INST_W-1:0]         if_id_inst;
    logic [cpu_pkg::PC_W-1:0]           if_id_pc_next;
    cpu_pkg::ctrl_t                     id_ctrl;
    logic [cpu_pkg::REG_ADDR_W-1:0]     id_src_a;
    logic [cpu_pkg::REG_ADDR_W-1:0]     id_src_b;
    logic                               id_uses_b;
    logic [cpu_pkg::DATA_W-1:0]         id_reg_a;
    logic [cpu_pkg::DATA_W-1:0]         id_reg_b;
    logic                               ex_mem_read;
    logic [cpu_pkg::REG_ADDR_W-1:0]     ex_dest;
    cpu_pkg::ex_mem_t                   ex_mem;
    cpu_pkg::mem_wb_t                   mem_wb;
    logic [cpu_pkg::DATA_W-1:0]         wb_data;

    // ******************************
    // IF and ID
    // ******************************
    fetch_unit u_fetch (
        .clk_50MHz       (clk_50MHz),
        .rst             (rst),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .inst_i          (inst_i),
        .pc_o            (imem_addr_o),
        .if_id_inst_o    (if_id_inst),
        .if_id_pc_next_o (if_id_pc_next)
    );

    decoder u_decoder (
        .inst_i   (if_id_inst),
        .ctrl_o   (id_ctrl),
        .src_a_o  (id_src_a),
        .src_b_o  (id_src_b),
        .uses_b_o (id_uses_b)
    );

    reg_file u_reg_file (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .rd_addr_a_i (id_src_a),
        .rd_addr_b_i (id_src_b),
        .wr_en_i     (mem_wb.reg_we),
        .wr_addr_i   (mem_wb.dest),
        .wr_data_i   (wb_data),
        .rd_data_a_o (id_reg_a),
        .rd_data_b_o (id_reg_b)
    );

    hazard_unit u_hazard (
        .src_a_i       (id_src_a),
        .src_b_i       (id_src_b),
        .uses_b_i      (id_uses_b),
        .ex_mem_read_i (ex_mem_read),
        .ex_dest_i     (ex_dest),
        .stall_o       (stall)
    );

    // ******************************
    // EXE, MEM and WB
    // ******************************
    execute_unit u_execute (
        .clk_50MHz       (clk_50MHz),
        .rst             (rst),
        .stall_i         (stall),
        .ctrl_i          (id_ctrl),
        .pc_next_i       (if_id_pc_next),
        .src_a_i         (id_src_a),
        .src_b_i         (id_src_b),
        .reg_a_i         (id_reg_a),
        .reg_b_i         (id_reg_b),
        .mem_wb_i        (mem_wb),
        .wb_data_i       (wb_data),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_mem_read_o   (ex_mem_read),
        .ex_dest_o       (ex_dest),
        .ex_mem_o        (ex_mem)
    );

    writeback_unit u_writeback (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .ex_mem_i    (ex_mem),
        .mem_rdata_i (dmem_rdata_i),
        .mem_wb_o    (mem_wb),
        .wb_data_o   (wb_data)
    );

    // memory stage straight from EXE/MEM
    assign dmem_addr_o  = ex_mem.alu_result;
    assign dmem_wdata_o = ex_mem.store_data;
    assign dmem_we_o    = ex_mem.mem_write;

    assign wb_we_o   = mem_wb.reg_we;
    assign wb_addr_o = mem_wb.dest;
    assign wb_data_o = wb_data;

endmodule

`default_nettype wire

/* test/cpu_ref_model.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// ******************************
// program generator
// ******************************
logic [cpu_pkg::DATA_W-1:0] model_regs [cpu_pkg::NUM_REGS];
logic [cpu_pkg::DATA_W-1:0] model_mem [DMEM_DEPTH];

function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// biased programs mostly read the newest destination
function automatic logic [2:0] pick_reg(input bit biased, input logic [2:0] last);
    if (biased && rand_below(4) != 0) begin
        return last;
    end
    return 3'(rand_below(cpu_pkg::NUM_REGS));
endfunction

task automatic build_program(input bit biased);
    logic [2:0]  last_dest;
    logic [2:0]  rx;
    logic [2:0]  ry;
    logic [2:0]  rz;
    logic [7:0]  imm8;
    logic [15:0] word;
    int          kind;
    int          off;
    last_dest = 3'd0;
    for (int i = 0; i < PROG_LEN; i++) begin
        rx   = pick_reg(biased, last_dest);
        ry   = pick_reg(biased, last_dest);
        rz   = 3'(rand_below(cpu_pkg::NUM_REGS));
        imm8 = 8'(rand_below(256));
        // forward only, never past the halt
        off  = 1 + rand_below(4);
        if (i + 1 + off > HALT_PC) begin
            off = HALT_PC - i - 1;
        end
        kind = rand_below(10);
        case (kind)
            0: word = {cpu_pkg::OP_RRR, rx, ry, rz, 2'b01};
            1: word = {cpu_pkg::OP_RRR, rx, ry, rz, 2'b11};
            2: word = {cpu_pkg::OP_LOGIC, rx, ry, 5'b01100};
            3: word = {cpu_pkg::OP_LOGIC, rx, ry, 5'b01101};
            4: word = {cpu_pkg::OP_ADDIU, rx, imm8};
            5: word = {cpu_pkg::OP_LI, rx, imm8};
            6: word = {cpu_pkg::OP_LW, rx, ry, imm8[4:0]};
            7: word = {cpu_pkg::OP_SW, rx, ry, imm8[4:0]};
            8: word = {cpu_pkg::OP_BEQZ, rx, 8'(off)};
            default: word = {cpu_pkg::OP_B, 11'(off)};
        endcase
        imem[i] = word;
        if (kind <= 1) begin
            last_dest = rz;
        end else if (kind <= 5) begin
            last_dest = rx;
        end else if (kind == 6) begin
            last_dest = ry;
        end
    end
    // B -1 spins on itself
    imem[HALT_PC] = {cpu_pkg::OP_B, 11'h7ff};
endtask

// ******************************
// instruction-level model
// ******************************
task automatic retire_write(input logic [2:0] dest, input logic [15:0] value);
    event_t ev;
    model_regs[dest] = value;
    ev.addr = {13'b0, dest};
    ev.data = value;
    exp_writes.push_back(ev);
endtask

task automatic run_model();
    logic [15:0] word;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] addr;
    event_t      ev;
    int          pc;
    for (int r = 0; r < cpu_pkg::NUM_REGS; r++) begin
        model_regs[r] = '0;
    end
    for (int m = 0; m < DMEM_DEPTH; m++) begin
        model_mem[m] = '0;
    end
    exp_writes.delete();
    exp_stores.delete();
    pc = 0;
    while (pc < HALT_PC) begin
        word = imem[pc];
        a    = model_regs[word[10:8]];
        b    = model_regs[word[7:5]];
        addr = a + {{11{word[4]}}, word[4:0]};
        pc   = pc + 1;
        case (word[15:11])
            cpu_pkg::OP_RRR:   retire_write(word[4:2], (word[1:0] == 2'b11) ? a - b : a + b);
            cpu_pkg::OP_LOGIC: retire_write(word[10:8], (word[4:0] == 5'b01101) ? a | b : a & b);
            cpu_pkg::OP_ADDIU: retire_write(word[10:8], a + {{8{word[7]}}, word[7:0]});
            cpu_pkg::OP_LI:    retire_write(word[10:8], {8'b0, word[7:0]});
            cpu_pkg::OP_LW:    retire_write(word[7:5], model_mem[addr[7:0]]);
            cpu_pkg::OP_SW: begin
                model_mem[addr[7:0]] = b;
                ev.addr = addr;
                ev.data = b;
                exp_stores.push_back(ev);
            end
            cpu_pkg::OP_BEQZ: begin
                if (a == '0) begin
                    pc = pc + int'($signed(word[7:0]));
                end
            end
            cpu_pkg::OP_B: pc = pc + int'($signed(word[10:0]));
            default: ;
        endcase
    end
endtask

`endif

/* test/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int PROG_LEN       = 48;
    localparam int HALT_PC        = PROG_LEN;
    localparam int DMEM_DEPTH     = 256;
    localparam int NUM_PROGRAMS   = 20;
    localparam int IDLE_CYCLES    = 10;
    // 20 programs x (49 instructions x 3 cycles + 20)
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [15:0] NOP_WORD = {cpu_pkg::OP_NOP, 11'b0};

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
    } event_t;

    logic                              clk_50MHz;
    logic                              rst;
    logic [cpu_pkg::PC_W-1:0]          imem_addr;
    logic [cpu_pkg::INST_W-1:0]        inst;
    logic [cpu_pkg::DATA_W-1:0]        dmem_addr;
    logic [cpu_pkg::DATA_W-1:0]        dmem_wdata;
    logic                              dmem_we;
    logic [cpu_pkg::DATA_W-1:0]        dmem_rdata;
    logic                              wb_we;
    logic [cpu_pkg::REG_ADDR_W-1:0]    wb_addr;
    logic [cpu_pkg::DATA_W-1:0]        wb_data;

    logic [cpu_pkg::INST_W-1:0]        imem [HALT_PC+1];
    logic [cpu_pkg::DATA_W-1:0]        dmem [DMEM_DEPTH];
    event_t                            exp_writes[$];
    event_t                            exp_stores[$];
    integer                            seed;
    int                                cycle_count;
    int                                writes_expected;
    int                                stores_expected;
    int                                writes_seen;
    int                                stores_seen;
    string                             test_name;

    `include "cpu_ref_model.svh"

    cpu_top DUT (
        .clk_50MHz    (clk_50MHz),
        .rst          (rst),
        .imem_addr_o  (imem_addr),
        .inst_i       (inst),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata),
        .wb_we_o      (wb_we),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    // wrong-path fetches past the halt see NOPs
    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        if (addr <= HALT_PC) begin
            return imem[addr];
        end
        return NOP_WORD;
    endfunction

    // ******************************
    // memories and event checker
    // ******************************
    always @(negedge clk_50MHz) begin
        event_t got;
        event_t want;
        if (rst && wb_we) begin
            got.addr = {13'b0, wb_addr};
            got.data = wb_data;
            assert (exp_writes.size() > 0) begin
                want = exp_writes.pop_front();
                assert (got == want) else report_failure($sformatf(
                    "Error: %s write %0d: expected r%0d=%04h, actual r%0d=%04h",
                    test_name, writes_seen, want.addr, want.data, got.addr, got.data));
                writes_seen++;
            end else begin
                report_failure($sformatf("%s: register write r%0d=%04h when none was expected",
                    test_name, wb_addr, wb_data));
            end
        end
        if (rst && dmem_we) begin
            got.addr = dmem_addr;
            got.data = dmem_wdata;
            assert (exp_stores.size() > 0) begin
                want = exp_stores.pop_front();
                assert (got == want) else report_failure($sformatf(
                    "Error: %s store %0d: expected mem[%04h]=%04h, actual mem[%04h]=%04h",
                    test_name, stores_seen, want.addr, want.data, got.addr, got.data));
                stores_seen++;
                dmem[dmem_addr[7:0]] = dmem_wdata;
            end else begin
                report_failure($sformatf("%s: store to %04h when none was expected",
                    test_name, dmem_addr));
            end
        end
        inst       = fetch_word(imem_addr);
        dmem_rdata = dmem[dmem_addr[7:0]];
    end

    always @(posedge clk_50MHz) begin
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES) else report_failure($sformatf(
            "timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    task automatic run_program(input int idx);
        @(negedge clk_50MHz);
        rst       = 1'b0;
        test_name = $sformatf("program %0d", idx);
        build_program(idx % 2 == 1);
        for (int a = 0; a < DMEM_DEPTH; a++) begin
            dmem[a] = '0;
        end
        run_model();
        writes_expected = exp_writes.size();
        stores_expected = exp_stores.size();
        writes_seen     = 0;
        stores_seen     = 0;
        repeat (2) @(negedge clk_50MHz);
        rst = 1'b1;
        while (imem_addr !== 16'(HALT_PC)) begin
            @(negedge clk_50MHz);
        end
        // older instructions drain early in the idle window
        repeat (IDLE_CYCLES) @(posedge clk_50MHz);
        assert (writes_seen == writes_expected && stores_seen == stores_expected)
            else report_failure($sformatf(
                "Error: %s events: expected %0d writes %0d stores, actual %0d writes %0d stores",
                test_name, writes_expected, stores_expected, writes_seen, stores_seen));
    endtask

    initial begin
        clk_50MHz   = 1'b0;
        rst         = 1'b0;
        inst        = NOP_WORD;
        dmem_rdata  = '0;
        seed        = 32'hbbdb_f178;
        cycle_count = 0;
        writes_seen = 0;
        stores_seen = 0;
        test_name   = "startup";
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+test
common/cpu_pkg.sv
rtl/fetch_unit.sv
decode/decoder.sv
decode/reg_file.sv
decode/hazard_unit.sv
execute/forward_unit.sv
execute/execute_unit.sv
rtl/writeback_unit.sv
rtl/cpu_top.sv
test/tb_cpu.sv
